/* xbar_regport.f */
+incdir+.
xbar_pkg.sv
xbar_regport_decode.sv
xbar_route_table.sv
xbar_switch.sv
xbar_resp_merge.sv
xbar_regport_top.sv
tb_xbar.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_xbar -f xbar_regport.f -o sim_xbar
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

out=$(./obj_dir/sim_xbar 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Verification passed"; then
  exit 0
fi

echo "Pass message not found"
exit 1

/* tb_xbar.sv */
//******************************
// Crossbar testbench
// Register checks, routing and contention
//******************************
`timescale 1ns/1ps
`include "xbar_defines.svh"

module tb_xbar;
  import xbar_pkg::*;

  localparam int N = `XBAR_NUM_PORTS;
  // 60 packets x 6 beats x 3 stall cycles, register phase, margin
  localparam int TIMEOUT = 4000;

  logic             clk;
  logic             reset;
  reg_wr_t          wr;
  reg_rd_t          rd;
  reg_resp_t        resp;
  axis_beat_t [N-1:0] s_beat;
  axis_beat_t [N-1:0] m_beat;
  logic [N-1:0]     s_valid;
  logic [N-1:0]     s_ready;
  logic [N-1:0]     m_valid;
  logic [N-1:0]     m_ready;

  int          cyc = 0;
  int          reg_errs = 0;
  int          strm_errs = 0;
  logic [31:0] rng = 32'h54e7_bb76;
  logic [3:0]  local_img;
  logic [15:0] tbl_img;
  logic        done;

  // Read expectations, request cycle and value
  int          rd_cyc_q[$];
  logic [31:0] rd_val_q[$];
  logic        due;
  logic [31:0] due_data;

  // Expected beats per [input][output]
  axis_beat_t  exp_q [N][N][$];
  axis_beat_t  exp_head [N];
  logic [N-1:0] exp_has;
  logic [N-1:0] out_sop;
  logic [N-1:0] cur_src;
  logic [N-1:0] pend_x;
  logic [N-1:0] pend_src;
  logic [N-1:0] pend_last;
  port_idx_t   in_tgt [N];

  xbar_regport_top u_xbar_regport_top (
    .clk       (clk),
    .reset     (reset),
    .i_wr      (wr),
    .i_rd      (rd),
    .o_resp    (resp),
    .i_s_beat  (s_beat),
    .i_s_valid (s_valid),
    .o_s_ready (s_ready),
    .o_m_beat  (m_beat),
    .o_m_valid (m_valid),
    .i_m_ready (m_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Local match goes through the table, everything else to the uplink
  function automatic port_idx_t route(input logic [7:0] dst);
    if (dst[7:4] == local_img)
      return port_idx_t'(tbl_img[dst[3:0]]);
    return '0;
  endfunction

  function automatic int pending_beats();
    int total;
    total = 0;
    for (int i = 0; i < N; i++)
      for (int o = 0; o < N; o++)
        total += exp_q[i][o].size();
    return total;
  endfunction

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic write_reg(input logic [13:0] addr, input logic [31:0] data);
    wr.stb  = 1'b1;
    wr.addr = addr;
    wr.data = data;
    @(posedge clk);
    #1;
    wr.stb = 1'b0;
  endtask

  task automatic read_reg(input logic [13:0] addr, input logic [31:0] expv, input bit mapped);
    rd.stb  = 1'b1;
    rd.addr = addr;
    if (mapped) begin
      rd_cyc_q.push_back(cyc);
      rd_val_q.push_back(expv);
    end
    @(posedge clk);
    #1;
    rd.stb = 1'b0;
  endtask

  task automatic run_stream(input int i, input int npkt, input bit contend);
    int          len;
    int          gap;
    logic [7:0]  dst;
    logic [31:0] r;
    axis_beat_t  b;
    port_idx_t   p;
    logic        xfer;
    for (int pk = 0; pk < npkt; pk++) begin
      len = 1 + int'(next_rand() % 6);
      r   = next_rand();
      if (contend)
        dst = {local_img, 4'h3};
      else if (r[8])
        dst = {local_img, r[3:0]};
      else
        dst = r[7:0];
      p = route(dst);
      in_tgt[i] = p;
      for (int bt = 0; bt < len; bt++) begin
        r = next_rand();
        b.data = {1'(i), r[30:0]};  // Top bit tags the source input
        if (bt == 0)
          b.data[7:0] = dst;
        b.last = (bt == len - 1);
        exp_q[i][p].push_back(b);
        gap = int'(next_rand() % 3);
        if (gap > 0)
          idle(gap);
        s_beat[i]  = b;
        s_valid[i] = 1'b1;
        do begin
          @(negedge clk);
          xfer = s_ready[i];
          @(posedge clk);
          #1;
        end while (!xfer);
        s_valid[i] = 1'b0;
      end
    end
  endtask

  initial begin
    forever begin
      @(posedge clk);
      #1;
      m_ready = (next_rand() % 4 != 0) ? 2'b11 : 2'(next_rand());
    end
  end

  // Model bookkeeping away from the rising edge
  always @(negedge clk) begin
    while (rd_cyc_q.size() > 0 && rd_cyc_q[0] + 2 < cyc) begin
      void'(rd_cyc_q.pop_front());
      void'(rd_val_q.pop_front());
    end
    due      = (rd_cyc_q.size() > 0) && (rd_cyc_q[0] + 2 == cyc);
    due_data = due ? rd_val_q[0] : '0;
    for (int o = 0; o < N; o++) begin
      if (pend_x[o]) begin
        if (exp_q[pend_src[o]][o].size() > 0)
          void'(exp_q[pend_src[o]][o].pop_front());
        out_sop[o] = pend_last[o];
        cur_src[o] = pend_src[o];
      end
      exp_has[o]   = exp_q[m_beat[o].data[31]][o].size() > 0;
      exp_head[o]  = exp_has[o] ? exp_q[m_beat[o].data[31]][o][0] : '0;
      pend_x[o]    = m_valid[o] && m_ready[o];
      pend_src[o]  = m_beat[o].data[31];
      pend_last[o] = m_beat[o].last;
    end
  end

  a_resp_valid: assert property (@(posedge clk) disable iff (reset) resp.valid == due)
    else begin
      reg_errs++;
      $display("FAILED resp.valid expected %h got %h", $sampled(due), $sampled(resp.valid));
    end

  a_resp_data: assert property (@(posedge clk) disable iff (reset)
    resp.valid && due |-> resp.data == due_data)
    else begin
      reg_errs++;
      $display("FAILED resp.data expected %h got %h", $sampled(due_data),
               $sampled(resp.data));
    end

  for (genvar go = 0; go < N; go++) begin : g_out
    a_beat: assert property (@(posedge clk) disable iff (reset)
      m_valid[go] && m_ready[go] |-> exp_has[go] && m_beat[go] == exp_head[go])
      else begin
        strm_errs++;
        $display("FAILED m_beat[%0d] expected %h got %h", go, $sampled(exp_head[go]),
                 $sampled(m_beat[go]));
      end
    a_contig: assert property (@(posedge clk) disable iff (reset)
      m_valid[go] && !out_sop[go] |-> m_beat[go].data[31] == cur_src[go])
      else begin
        strm_errs++;
        $display("FAILED m_beat[%0d].data[31] expected %h got %h", go,
                 $sampled(cur_src[go]), $sampled(m_beat[go].data[31]));
      end
  end

  for (genvar gi = 0; gi < N; gi++) begin : g_in
    // Input waiting behind the other source must stay stalled
    a_wait: assert property (@(posedge clk) disable iff (reset)
      s_valid[gi] && m_valid[in_tgt[gi]] && (m_beat[in_tgt[gi]].data[31] != 1'(gi))
      |-> !s_ready[gi])
      else begin
        strm_errs++;
        $display("FAILED s_ready[%0d] expected 0 got %h", gi, $sampled(s_ready[gi]));
      end
  end

  a_idle: assert property (@(posedge clk) disable iff (reset)
    done |-> m_valid == '0 && s_ready == '0)
    else begin
      strm_errs++;
      $display("FAILED idle m_valid %h s_ready %h, expected 0", $sampled(m_valid),
               $sampled(s_ready));
    end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      $display("Timeout after %0d cycles, %0d beats never arrived", cyc, pending_beats());
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] v;
    reset     = 1'b1;
    wr        = '0;
    rd        = '0;
    s_beat    = '0;
    s_valid   = '0;
    m_ready   = '0;
    done      = 1'b0;
    due       = 1'b0;
    due_data  = '0;
    exp_has   = '0;
    out_sop   = '1;
    cur_src   = '0;
    pend_x    = '0;
    pend_src  = '0;
    pend_last = '0;
    local_img = '0;
    tbl_img   = '0;
    for (int i = 0; i < N; i++)
      in_tgt[i] = '0;
    for (int o = 0; o < N; o++)
      exp_head[o] = '0;
    idle(4);
    reset = 1'b0;

    read_reg(`XBAR_REG_VERSION, 32'd1, 1'b1);
    read_reg(`XBAR_REG_NUM_PORTS, 32'd2, 1'b1);
    read_reg(`XBAR_REG_LOCAL_ADDR, 32'd0, 1'b1);
    for (int n = 0; n < 4; n++)
      read_reg(`XBAR_REG_TABLE_BASE + 14'(4 * n), 32'd0, 1'b1);  // Reset image
    idle(3);
    read_reg(14'h00c, 32'd0, 1'b0);
    idle(3);
    read_reg(14'h100, 32'd0, 1'b0);
    idle(4);

    write_reg(`XBAR_REG_LOCAL_ADDR, 32'habcd_1235);
    local_img = 4'h5;
    for (int n = 0; n < 16; n++) begin
      v = next_rand();
      if (n == 3)
        v[0] = 1'b1;  // Contention target lands on port 1
      tbl_img[n] = v[0];
      write_reg(`XBAR_REG_TABLE_BASE + 14'(4 * n), v);
    end
    idle(2);
    read_reg(`XBAR_REG_LOCAL_ADDR, {28'd0, local_img}, 1'b1);
    for (int n = 0; n < 16; n++)
      read_reg(`XBAR_REG_TABLE_BASE + 14'(4 * n), {31'd0, tbl_img[n]}, 1'b1);
    idle(4);

    fork
      run_stream(0, 20, 1'b0);
      run_stream(1, 20, 1'b0);
    join
    fork
      run_stream(0, 10, 1'b1);
      run_stream(1, 10, 1'b1);
    join
    while (pending_beats() > 0)
      idle(1);
    idle(3);
    done = 1'b1;
    idle(3);
    done = 1'b0;

    $display("Errors: register %0d, stream %0d", reg_errs, strm_errs);
    if (reg_errs == 0 && strm_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* xbar_regport_top.sv */
//******************************
// Crossbar with register port
// Decode, route table, switch, merge
//******************************
`timescale 1ns/1ps
`include "xbar_defines.svh"

module xbar_regport_top (
  input  logic                                       clk,
  input  logic                                       reset,
  input  xbar_pkg::reg_wr_t                          i_wr,
  input  xbar_pkg::reg_rd_t                          i_rd,
  output xbar_pkg::reg_resp_t                        o_resp,
  input  xbar_pkg::axis_beat_t [`XBAR_NUM_PORTS-1:0] i_s_beat,
  input  logic [`XBAR_NUM_PORTS-1:0]                 i_s_valid,
  output logic [`XBAR_NUM_PORTS-1:0]                 o_s_ready,
  output xbar_pkg::axis_beat_t [`XBAR_NUM_PORTS-1:0] o_m_beat,
  output logic [`XBAR_NUM_PORTS-1:0]                 o_m_valid,
  input  logic [`XBAR_NUM_PORTS-1:0]                 i_m_ready
);
  import xbar_pkg::*;

  set_bus_t                                        set_bus;
  reg_resp_t                                       glob_resp;
  reg_resp_t                                       tbl_resp;
  logic [3:0]                                      local_addr;
  logic [`XBAR_NUM_PORTS-1:0][`XBAR_TBL_IDX_W-1:0] lookup_idx;
  port_idx_t [`XBAR_NUM_PORTS-1:0]                 lookup_port;

  xbar_regport_decode u_decode (
    .clk          (clk),
    .reset        (reset),
    .i_wr         (i_wr),
    .i_rd         (i_rd),
    .o_set        (set_bus),
    .o_glob_resp  (glob_resp),
    .o_local_addr (local_addr)
  );

  xbar_route_table u_route_table (
    .clk           (clk),
    .reset         (reset),
    .i_set         (set_bus),
    .o_tbl_resp    (tbl_resp),
    .i_lookup_idx  (lookup_idx),
    .o_lookup_port (lookup_port)
  );

  xbar_switch u_switch (
    .clk           (clk),
    .reset         (reset),
    .i_beat        (i_s_beat),
    .i_valid       (i_s_valid),
    .o_ready       (o_s_ready),
    .o_beat        (o_m_beat),
    .o_valid       (o_m_valid),
    .i_ready       (i_m_ready),
    .i_local_addr  (local_addr),
    .o_lookup_idx  (lookup_idx),
    .i_lookup_port (lookup_port)
  );

  xbar_resp_merge u_resp_merge (
    .clk         (clk),
    .reset       (reset),
    .i_glob_resp (glob_resp),
    .i_tbl_resp  (tbl_resp),
    .o_resp      (o_resp)
  );

endmodule

/* xbar_resp_merge.sv */
//******************************
// Read response merge
// One registered response channel
//******************************
`timescale 1ns/1ps

module xbar_resp_merge (
  input  logic                clk,
  input  logic                reset,
  input  xbar_pkg::reg_resp_t i_glob_resp,
  input  xbar_pkg::reg_resp_t i_tbl_resp,
  output xbar_pkg::reg_resp_t o_resp
);
  import xbar_pkg::*;

  reg_resp_t resp_q;

  always_ff @(posedge clk) begin
    if (reset)
      resp_q.valid <= 1'b0;
    else
      resp_q.valid <= i_glob_resp.valid || i_tbl_resp.valid;  // Single cycle
  end

  // Data follows whichever source answered
  always_ff @(posedge clk) begin
    if (i_glob_resp.valid)
      resp_q.data <= i_glob_resp.data;
    else if (i_tbl_resp.valid)
      resp_q.data <= i_tbl_resp.data;
  end

  assign o_resp = resp_q;

  // Decode sends each read to one source only
  a_no_overlap: assert property (@(posedge clk) disable iff (reset)
    !(i_glob_resp.valid && i_tbl_resp.valid))
    else $error("global and table responses valid together");

endmodule

/* xbar_switch.sv */
//******************************
// Packet switch
// Round-robin per output, packet lock
//******************************
`timescale 1ns/1ps
`include "xbar_defines.svh"

module xbar_switch (
  input  logic                                              clk,
  input  logic                                              reset,
  input  xbar_pkg::axis_beat_t [`XBAR_NUM_PORTS-1:0]        i_beat,
  input  logic [`XBAR_NUM_PORTS-1:0]                        i_valid,
  output logic [`XBAR_NUM_PORTS-1:0]                        o_ready,
  output xbar_pkg::axis_beat_t [`XBAR_NUM_PORTS-1:0]        o_beat,
  output logic [`XBAR_NUM_PORTS-1:0]                        o_valid,
  input  logic [`XBAR_NUM_PORTS-1:0]                        i_ready,
  input  logic [3:0]                                        i_local_addr,
  output logic [`XBAR_NUM_PORTS-1:0][`XBAR_TBL_IDX_W-1:0]   o_lookup_idx,
  input  xbar_pkg::port_idx_t [`XBAR_NUM_PORTS-1:0]         i_lookup_port
);
  import xbar_pkg::*;

  localparam int N = `XBAR_NUM_PORTS;

  logic [N-1:0]                     sop_q;     // Next beat starts a packet
  logic [N-1:0][`XBAR_DST_WIDTH-1:0] dst;
  port_idx_t [N-1:0]                dest_port;
  logic [N-1:0][N-1:0]              req;       // [output][input]
  logic [N-1:0][N-1:0]              in_gnt;    // [input][output]
  logic [N-1:0]                     lock_q;
  port_idx_t [N-1:0]                grant_q;
  port_idx_t [N-1:0]                rr_ptr_q;
  port_idx_t [N-1:0]                gnt_idx;
  logic [N-1:0]                     gnt_valid;
  logic [N-1:0]                     xfer_last;

  function automatic port_idx_t next_idx(input port_idx_t idx);
    return port_idx_t'((int'(idx) + 1) % N);
  endfunction

  // Destination from the first beat
  always_comb begin
    for (int i = 0; i < N; i++) begin
      dst[i]          = i_beat[i].data[`XBAR_DST_WIDTH-1:0];
      o_lookup_idx[i] = dst[i][`XBAR_TBL_IDX_W-1:0];
      if (dst[i][`XBAR_DST_WIDTH-1:`XBAR_TBL_IDX_W] == i_local_addr)
        dest_port[i] = i_lookup_port[i];
      else
        dest_port[i] = '0;  // Off-node traffic goes to the uplink
    end
  end

  always_comb begin
    for (int o = 0; o < N; o++)
      for (int i = 0; i < N; i++)
        req[o][i] = i_valid[i] && sop_q[i] && (dest_port[i] == port_idx_t'(o));
  end

  // Grant held while locked or taken by the first requester from the pointer
  always_comb begin
    port_idx_t cand;
    cand = '0;
    for (int o = 0; o < N; o++) begin
      gnt_idx[o]   = lock_q[o] ? grant_q[o] : rr_ptr_q[o];
      gnt_valid[o] = lock_q[o];
      if (!lock_q[o]) begin
        for (int k = N - 1; k >= 0; k--) begin
          cand = port_idx_t'((int'(rr_ptr_q[o]) + k) % N);
          if (req[o][cand]) begin
            gnt_idx[o]   = cand;
            gnt_valid[o] = 1'b1;
          end
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N; i++)
      for (int o = 0; o < N; o++)
        in_gnt[i][o] = gnt_valid[o] && (gnt_idx[o] == port_idx_t'(i));
    for (int o = 0; o < N; o++) begin
      o_beat[o]    = i_beat[gnt_idx[o]];
      o_valid[o]   = gnt_valid[o] && i_valid[gnt_idx[o]];
      xfer_last[o] = o_valid[o] && i_ready[o] && o_beat[o].last;
    end
    for (int i = 0; i < N; i++)
      o_ready[i] = |(in_gnt[i] & i_ready);  // Only the granted output can pull
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sop_q <= '1;
    end else begin
      for (int i = 0; i < N; i++)
        if (i_valid[i] && o_ready[i])
          sop_q[i] <= i_beat[i].last;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lock_q   <= '0;
      grant_q  <= '0;
      rr_ptr_q <= '0;
    end else begin
      for (int o = 0; o < N; o++) begin
        if (!lock_q[o])
          grant_q[o] <= gnt_idx[o];
        if (xfer_last[o]) begin
          lock_q[o]   <= 1'b0;
          rr_ptr_q[o] <= next_idx(gnt_idx[o]);  // Skip past input just served
        end else if (gnt_valid[o]) begin
          lock_q[o] <= 1'b1;                    // Also holds grant through a stall
        end
      end
    end
  end

  for (genvar gi = 0; gi < N; gi++) begin : g_in_chk
    a_one_output: assert property (@(posedge clk) disable iff (reset)
      $onehot0(in_gnt[gi]))
      else $error("input %0d granted to more than one output", gi);
  end

  for (genvar go = 0; go < N; go++) begin : g_out_chk
    a_lock_hold: assert property (@(posedge clk) disable iff (reset)
      gnt_valid[go] && !xfer_last[go] |=> gnt_valid[go] && $stable(gnt_idx[go]))
      else $error("output %0d grant changed inside a packet", go);
  end

endmodule

/* xbar_route_table.sv */
//******************************
// Route table
// Settings bus access and lookup
//******************************
`timescale 1ns/1ps
`include "xbar_defines.svh"

module xbar_route_table (
  input  logic                                              clk,
  input  logic                                              reset,
  input  xbar_pkg::set_bus_t                                i_set,
  output xbar_pkg::reg_resp_t                               o_tbl_resp,
  input  logic [`XBAR_NUM_PORTS-1:0][`XBAR_TBL_IDX_W-1:0]   i_lookup_idx,
  output xbar_pkg::port_idx_t [`XBAR_NUM_PORTS-1:0]         o_lookup_port
);
  import xbar_pkg::*;

  localparam int PW = $bits(port_idx_t);

  port_idx_t table_q [`XBAR_TABLE_DEPTH];
  reg_resp_t resp_q;

  // Entries reset to uplink
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int n = 0; n < `XBAR_TABLE_DEPTH; n++)
        table_q[n] <= '0;
    end else if (i_set.wr_stb) begin
      table_q[i_set.idx] <= i_set.data[PW-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      resp_q.valid <= 1'b0;
    else
      resp_q.valid <= i_set.rd_stb;
  end

  // Read-back, zero-extended
  always_ff @(posedge clk) begin
    if (i_set.rd_stb)
      resp_q.data <= {{(`XBAR_REG_DWIDTH-PW){1'b0}}, table_q[i_set.idx]};
  end

  assign o_tbl_resp = resp_q;

  // One lookup per input, all in parallel
  always_comb begin
    for (int i = 0; i < `XBAR_NUM_PORTS; i++)
      o_lookup_port[i] = table_q[i_lookup_idx[i]];
  end

endmodule

/* xbar_regport_decode.sv */
//******************************
// Register port decode
// Global registers and route table window
//******************************
`timescale 1ns/1ps
`include "xbar_defines.svh"

module xbar_regport_decode (
  input  logic                clk,
  input  logic                reset,
  input  xbar_pkg::reg_wr_t   i_wr,
  input  xbar_pkg::reg_rd_t   i_rd,
  output xbar_pkg::set_bus_t  o_set,
  output xbar_pkg::reg_resp_t o_glob_resp,
  output logic [3:0]          o_local_addr
);
  import xbar_pkg::*;

  logic [3:0] local_addr_q;
  reg_resp_t  glob_resp_q;
  set_bus_t   set_d;
  logic       wr_tbl;
  logic       rd_tbl;

  // Word-aligned hit inside the table window
  function automatic logic tbl_hit(input logic [`XBAR_REG_AWIDTH-1:0] addr);
    return (addr >= `XBAR_REG_TABLE_BASE) &&
           (addr < `XBAR_REG_TABLE_BASE + 4 * `XBAR_TABLE_DEPTH) &&
           (addr[1:0] == 2'b00);
  endfunction

  function automatic logic [`XBAR_TBL_IDX_W-1:0] tbl_idx(
    input logic [`XBAR_REG_AWIDTH-1:0] addr
  );
    logic [`XBAR_REG_AWIDTH-1:0] offs;
    offs = addr - `XBAR_REG_TABLE_BASE;
    return offs[`XBAR_TBL_IDX_W+1:2];
  endfunction

  function automatic logic glob_hit(input logic [`XBAR_REG_AWIDTH-1:0] addr);
    return (addr == `XBAR_REG_VERSION) || (addr == `XBAR_REG_NUM_PORTS) ||
           (addr == `XBAR_REG_LOCAL_ADDR);
  endfunction

  assign wr_tbl = i_wr.stb && tbl_hit(i_wr.addr);
  assign rd_tbl = i_rd.stb && tbl_hit(i_rd.addr) && !wr_tbl;  // Write wins a same-cycle clash

  always_comb begin
    set_d.wr_stb = wr_tbl;
    set_d.rd_stb = rd_tbl;
    set_d.idx    = wr_tbl ? tbl_idx(i_wr.addr) : tbl_idx(i_rd.addr);
    set_d.data   = i_wr.data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      local_addr_q      <= '0;
      glob_resp_q.valid <= 1'b0;
    end else begin
      if (i_wr.stb && (i_wr.addr == `XBAR_REG_LOCAL_ADDR))
        local_addr_q <= i_wr.data[3:0];
      glob_resp_q.valid <= i_rd.stb && glob_hit(i_rd.addr);  // Unmapped reads die here
    end
  end

  // Read data
  always_ff @(posedge clk) begin
    case (i_rd.addr)
      `XBAR_REG_VERSION:   glob_resp_q.data <= `XBAR_VERSION;
      `XBAR_REG_NUM_PORTS: glob_resp_q.data <= `XBAR_REG_DWIDTH'(`XBAR_NUM_PORTS);
      default:             glob_resp_q.data <= {{(`XBAR_REG_DWIDTH-4){1'b0}}, local_addr_q};
    endcase
  end

  assign o_set        = set_d;
  assign o_glob_resp  = glob_resp_q;
  assign o_local_addr = local_addr_q;

endmodule

/* xbar_pkg.sv */
//******************************
// Crossbar types
// Stream beat, register and settings bus structs
//******************************
`include "xbar_defines.svh"

package xbar_pkg;

  // One stream beat
  typedef struct packed {
    logic [`XBAR_DATA_WIDTH-1:0] data;
    logic                        last;
  } axis_beat_t;

  typedef struct packed {
    logic                        stb;
    logic [`XBAR_REG_AWIDTH-1:0] addr;
    logic [`XBAR_REG_DWIDTH-1:0] data;
  } reg_wr_t;

  typedef struct packed {
    logic                        stb;
    logic [`XBAR_REG_AWIDTH-1:0] addr;
  } reg_rd_t;

  typedef struct packed {
    logic                        valid;
    logic [`XBAR_REG_DWIDTH-1:0] data;
  } reg_resp_t;

  // Route table access, index is the word offset in the table window
  typedef struct packed {
    logic                        wr_stb;
    logic                        rd_stb;
    logic [`XBAR_TBL_IDX_W-1:0]  idx;
    logic [`XBAR_REG_DWIDTH-1:0] data;
  } set_bus_t;

  typedef logic [$clog2(`XBAR_NUM_PORTS)-1:0] port_idx_t;

endpackage

/* xbar_defines.svh */
//******************************
// Crossbar register port parameters
// Port count, widths, register map and version
//******************************
`ifndef XBAR_DEFINES_SVH
`define XBAR_DEFINES_SVH

// Stream side
`define XBAR_NUM_PORTS   2
`define XBAR_DATA_WIDTH  32
`define XBAR_DST_WIDTH   8   // Destination in low bits of first beat
`define XBAR_TABLE_DEPTH 16
`define XBAR_TBL_IDX_W   4   // log2 of table depth, also lower nibble of dst

// Register port
`define XBAR_REG_AWIDTH  14
`define XBAR_REG_DWIDTH  32
`define XBAR_VERSION     32'd1

// Register map, byte addresses
`define XBAR_REG_VERSION    14'h000
`define XBAR_REG_NUM_PORTS  14'h004
`define XBAR_REG_LOCAL_ADDR 14'h008
`define XBAR_REG_TABLE_BASE 14'h040  // Entry n at base + 4*n

`endif
